//--- common/print_types_pkg.sv
package print_types_pkg;

    // ascii character on the transmit byte strobe
    typedef logic [7:0] char_t;

    // raw sensor and clock readings
    typedef logic [8:0] dist_t;
    typedef logic [7:0] reading_t;
    typedef logic [5:0] sec_t;
    typedef logic [5:0] min_t;
    typedef logic [4:0] hour_t;

    // mode select as it arrives from the board
    typedef logic [1:0] mode_t;

    localparam mode_t MODE_DIST    = 2'd2;
    localparam mode_t MODE_CLIMATE = 2'd3;

    // decimal digits, slot 0 sits in the low nibble
    typedef logic [3:0] digit_t;

    localparam int DIGIT_SLOTS = 6;

    typedef digit_t [DIGIT_SLOTS-1:0] digit_array_t;

    // position inside the line being printed
    typedef logic [4:0] char_idx_t;

    // message kinds, modes 0 and 1 both print the clock
    typedef enum logic [1:0] {
        MSG_CLOCK,
        MSG_DIST,
        MSG_CLIMATE
    } msg_kind_t;

    // sequencer states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CONVERT,
        ST_SEND,
        ST_DONE
    } ctrl_state_t;

endpackage

//--- common/print_text_pkg.sv
package print_text_pkg;

    import print_types_pkg::*;

    localparam char_t ASCII_ZERO = 8'h30;

    localparam char_idx_t MSG_LEN_DIST    = 5'd13;
    localparam char_idx_t MSG_LEN_CLOCK   = 5'd14;
    localparam char_idx_t MSG_LEN_CLIMATE = 5'd20;

    localparam int MAX_MSG_LEN = 20;

    // layout entry: bit 8 set means the low bits name a digit slot,
    // otherwise the low byte is the literal character
    typedef logic [8:0] layout_t;

    localparam int LAYOUT_SLOT_BIT = 8;

    function automatic layout_t lit(input char_t c);
        return {1'b0, c};
    endfunction

    function automatic layout_t slot(input int unsigned n);
        return {1'b1, 8'(n)};
    endfunction

    // "distance: ddd", rest of the table is unused padding
    localparam layout_t DIST_LAYOUT [MAX_MSG_LEN] = '{
        lit("d"), lit("i"), lit("s"), lit("t"), lit("a"),
        lit("n"), lit("c"), lit("e"), lit(":"), lit(" "),
        slot(0), slot(1), slot(2),
        lit(" "), lit(" "), lit(" "), lit(" "), lit(" "), lit(" "), lit(" ")
    };

    // "time: HH:MM:SS"
    localparam layout_t CLOCK_LAYOUT [MAX_MSG_LEN] = '{
        lit("t"), lit("i"), lit("m"), lit("e"), lit(":"), lit(" "),
        slot(0), slot(1), lit(":"),
        slot(2), slot(3), lit(":"),
        slot(4), slot(5),
        lit(" "), lit(" "), lit(" "), lit(" "), lit(" "), lit(" ")
    };

    // "temp: ttt humid: hhh", fills the whole table
    localparam layout_t CLIMATE_LAYOUT [MAX_MSG_LEN] = '{
        lit("t"), lit("e"), lit("m"), lit("p"), lit(":"), lit(" "),
        slot(0), slot(1), slot(2),
        lit(" "), lit("h"), lit("u"), lit("m"), lit("i"), lit("d"),
        lit(":"), lit(" "),
        slot(3), slot(4), slot(5)
    };

endpackage

//--- common/print_seq_if.sv
`timescale 1ns/1ps

interface print_seq_if;

    import print_types_pkg::*;

    msg_kind_t    kind;
    digit_array_t digits;
    char_idx_t    char_idx;
    logic         last;
    logic         send;

    modport fsm       (output send, input last);
    modport counter   (input send, input kind, output char_idx, output last);
    modport converter (output kind, output digits);
    modport composer  (input send, input kind, input digits, input char_idx);

endinterface

//--- verilog/print_ctrl_fsm.sv
`timescale 1ns/1ps

module print_ctrl_fsm (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic       convert_done,
    print_seq_if.fsm   seq,
    output logic       capture,
    output logic       clear,
    output logic       busy,
    output logic       done
);

    import print_types_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        accept;

    // start only counts in idle, and not in the cycle that done is shown
    assign accept  = (state == ST_IDLE) && start && !done;
    assign capture = accept;
    assign clear   = (state == ST_CONVERT);
    assign seq.send = (state == ST_SEND);
    assign busy    = (state != ST_IDLE);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_next = ST_CONVERT;
                end
            end
            ST_CONVERT: begin
                if (convert_done) begin
                    state_next = ST_SEND;
                end
            end
            ST_SEND: begin
                if (seq.last) begin
                    state_next = ST_DONE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
            done  <= 1'b0;
        end else begin
            state <= state_next;
            // the last character leaves the composer during ST_DONE
            done  <= (state == ST_DONE);
        end
    end

    // sending is only ever entered from the conversion step
    assert property (@(posedge clk) disable iff (reset)
        seq.send |-> $past(state) inside {ST_CONVERT, ST_SEND});

    // a start that arrives mid-message never opens a second one
    assert property (@(posedge clk) disable iff (reset)
        start && (busy || done) |=> state != ST_CONVERT);

endmodule

//--- verilog/char_counter.sv
`timescale 1ns/1ps

module char_counter (
    input  logic         clk,
    input  logic         reset,
    input  logic         clear,
    print_seq_if.counter seq
);

    import print_types_pkg::*;
    import print_text_pkg::*;

    char_idx_t idx;
    char_idx_t msg_len;

    // line length of the kind latched at capture
    always_comb begin
        case (seq.kind)
            MSG_DIST:    msg_len = MSG_LEN_DIST;
            MSG_CLIMATE: msg_len = MSG_LEN_CLIMATE;
            default:     msg_len = MSG_LEN_CLOCK;
        endcase
    end

    assign seq.last     = (idx == msg_len - 5'd1);
    assign seq.char_idx = idx;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idx <= '0;
        end else if (clear) begin
            idx <= '0;
        end else if (seq.send) begin
            // wrap on the final character so the index rests at zero
            idx <= seq.last ? 5'd0 : idx + 5'd1;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        idx < msg_len);

endmodule

//--- verilog/reading_to_decimal.sv
`timescale 1ns/1ps

module reading_to_decimal (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      capture,
    input  print_types_pkg::dist_t    distance_bin,
    input  print_types_pkg::mode_t    mode,
    input  print_types_pkg::sec_t     sec,
    input  print_types_pkg::min_t     min,
    input  print_types_pkg::hour_t    hour,
    input  print_types_pkg::reading_t humid,
    input  print_types_pkg::reading_t temp,
    output logic                      convert_done,
    print_seq_if.converter            seq
);

    import print_types_pkg::*;

    msg_kind_t    kind_q;
    logic         valid_q;
    dist_t        dist_q;
    sec_t         sec_q;
    min_t         min_q;
    hour_t        hour_q;
    reading_t     humid_q;
    reading_t     temp_q;
    digit_array_t conv_digits;
    digit_array_t digits_q;

    // three digits, hundreds in the low nibble
    function automatic logic [11:0] split3(input logic [8:0] v);
        digit_t h;
        digit_t t;
        digit_t o;
        h = digit_t'(v / 9'd100);
        t = digit_t'((v / 9'd10) % 9'd10);
        o = digit_t'(v % 9'd10);
        return {o, t, h};
    endfunction

    // two digits, tens in the low nibble
    function automatic logic [7:0] split2(input logic [5:0] v);
        return {digit_t'(v % 6'd10), digit_t'(v / 6'd10)};
    endfunction

    function automatic logic all_decimal(input digit_array_t d);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < DIGIT_SLOTS; i++) begin
            ok = ok && (d[i] <= 4'd9);
        end
        return ok;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            kind_q  <= MSG_CLOCK;
            valid_q <= 1'b0;
        end else begin
            valid_q <= capture;
            if (capture) begin
                case (mode)
                    MODE_DIST:    kind_q <= MSG_DIST;
                    MODE_CLIMATE: kind_q <= MSG_CLIMATE;
                    default:      kind_q <= MSG_CLOCK;
                endcase
            end
        end
    end

    // only the readings the selected message prints are taken
    always_ff @(posedge clk) begin
        if (capture) begin
            case (mode)
                MODE_DIST: begin
                    dist_q <= distance_bin;
                end
                MODE_CLIMATE: begin
                    temp_q  <= temp;
                    humid_q <= humid;
                end
                default: begin
                    hour_q <= hour;
                    min_q  <= min;
                    sec_q  <= sec;
                end
            endcase
        end
    end

    always_comb begin
        case (kind_q)
            MSG_DIST:    conv_digits = {12'd0, split3(dist_q)};
            MSG_CLIMATE: conv_digits = {split3({1'b0, humid_q}), split3({1'b0, temp_q})};
            default:     conv_digits = {split2(sec_q), split2(min_q), split2({1'b0, hour_q})};
        endcase
    end

    always_ff @(posedge clk) begin
        if (valid_q) begin
            digits_q <= conv_digits;
        end
    end

    // high in the cycle whose closing edge loads the digit register
    assign convert_done = valid_q;
    assign seq.kind     = kind_q;
    assign seq.digits   = digits_q;

    assert property (@(posedge clk) disable iff (reset)
        convert_done |=> all_decimal(digits_q));

endmodule

//--- verilog/message_composer.sv
`timescale 1ns/1ps

module message_composer (
    input  logic                   clk,
    input  logic                   reset,
    print_seq_if.composer          seq,
    output print_types_pkg::char_t tx_data,
    output logic                   tx_wr
);

    import print_types_pkg::*;
    import print_text_pkg::*;

    layout_t entry;
    char_t   ch;
    digit_t  dig;

    // layout lookup for the current kind and position
    always_comb begin
        case (seq.kind)
            MSG_DIST:    entry = DIST_LAYOUT[seq.char_idx];
            MSG_CLIMATE: entry = CLIMATE_LAYOUT[seq.char_idx];
            default:     entry = CLOCK_LAYOUT[seq.char_idx];
        endcase
    end

    assign dig = seq.digits[entry[2:0]];

    always_comb begin
        if (entry[LAYOUT_SLOT_BIT]) begin
            ch = ASCII_ZERO + char_t'(dig);
        end else begin
            ch = entry[7:0];
        end
    end

    // one register stage between the send cycle and the fifo strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_data <= '0;
            tx_wr   <= 1'b0;
        end else begin
            tx_wr   <= seq.send;
            tx_data <= seq.send ? ch : 8'h00;
        end
    end

    // printable ascii only, digits included
    assert property (@(posedge clk) disable iff (reset)
        tx_wr |-> (tx_data >= 8'h20) && (tx_data <= 8'h7e));

endmodule

//--- verilog/print_gen_top.sv
`timescale 1ns/1ps

module print_gen_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  print_types_pkg::dist_t     distance_bin,
    input  print_types_pkg::mode_t     mode,
    input  print_types_pkg::sec_t      sec,
    input  print_types_pkg::min_t      min,
    input  print_types_pkg::hour_t     hour,
    input  print_types_pkg::reading_t  humid,
    input  print_types_pkg::reading_t  temp,
    output print_types_pkg::char_t     tx_data,
    output logic                       tx_wr,
    output logic                       done,
    output logic                       busy
);

    logic capture;
    logic convert_done;
    logic clear;

    print_seq_if seq ();

    print_ctrl_fsm u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .convert_done (convert_done),
        .seq          (seq),
        .capture      (capture),
        .clear        (clear),
        .busy         (busy),
        .done         (done)
    );

    char_counter u_counter (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .seq   (seq)
    );

    reading_to_decimal u_convert (
        .clk          (clk),
        .reset        (reset),
        .capture      (capture),
        .distance_bin (distance_bin),
        .mode         (mode),
        .sec          (sec),
        .min          (min),
        .hour         (hour),
        .humid        (humid),
        .temp         (temp),
        .convert_done (convert_done),
        .seq          (seq)
    );

    message_composer u_compose (
        .clk     (clk),
        .reset   (reset),
        .seq     (seq),
        .tx_data (tx_data),
        .tx_wr   (tx_wr)
    );

endmodule

//--- verif/print_gen_tb.sv
`timescale 1ns/1ps

module print_gen_tb;

    import print_types_pkg::*;

    // about 40 messages of at most 23 cycles, idle checks and margin
    localparam int MAX_CYCLES = 3000;

    logic     clk;
    logic     reset;
    logic     start;
    dist_t    distance_bin;
    mode_t    mode;
    sec_t     sec;
    min_t     min;
    hour_t    hour;
    reading_t humid;
    reading_t temp;
    char_t    tx_data;
    logic     tx_wr;
    logic     done;
    logic     busy;

    // what the last message looked like on the outputs
    char_t got_chars [32];
    int    got_len;
    int    first_wr;
    int    done_at;
    logic  contiguous;
    logic  busy_held;
    logic  done_busy;
    logic  done_wr;
    logic  done_after;
    int    cycles;

    print_gen_top uut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("tests failed");
            $fatal(1);
        end
    end

    task automatic halt_run();
        $display("tests failed");
        $fatal(1, "first error ends the run");
    endtask

    task automatic check_char(input string name, input char_t exp, input char_t act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
            halt_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
            halt_run();
        end
    endtask

    task automatic check_len(input string name, input char_idx_t exp, input char_idx_t act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
            halt_run();
        end
    endtask

    // zero padded decimal of fixed width
    function automatic string pad_dec(input int unsigned value, input int width);
        string s;
        s = $sformatf("%0d", value);
        while (s.len() < width) begin
            s = {"0", s};
        end
        return s;
    endfunction

    // reference line for the readings present at the start edge
    function automatic string expected_line(input mode_t m, input dist_t d, input hour_t h,
            input min_t mi, input sec_t s, input reading_t t, input reading_t hu);
        if (m == 2'd2) begin
            return {"distance: ", pad_dec(32'(d), 3)};
        end else if (m == 2'd3) begin
            return {"temp: ", pad_dec(32'(t), 3), " humid: ", pad_dec(32'(hu), 3)};
        end
        return {"time: ", pad_dec(32'(h), 2), ":", pad_dec(32'(mi), 2), ":",
                pad_dec(32'(s), 2)};
    endfunction

    // returns right after the start edge E0
    task automatic drive_start(input mode_t m, input dist_t d, input hour_t h, input min_t mi,
            input sec_t s, input reading_t t, input reading_t hu);
        @(posedge clk);
        start        <= 1'b1;
        mode         <= m;
        distance_bin <= d;
        hour         <= h;
        min          <= mi;
        sec          <= s;
        temp         <= t;
        humid        <= hu;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // samples at falling edges, n counts rising edges after E0
    task automatic collect_message();
        int   n;
        logic prev_wr;
        n          = 0;
        prev_wr    = 1'b0;
        got_len    = 0;
        first_wr   = -1;
        contiguous = 1'b1;
        busy_held  = 1'b1;
        @(negedge clk);
        while (done !== 1'b1) begin
            if (tx_wr === 1'b1) begin
                if (first_wr < 0) begin
                    first_wr = n;
                end else if (prev_wr !== 1'b1) begin
                    contiguous = 1'b0;
                end
                if (got_len < 32) begin
                    got_chars[got_len] = tx_data;
                end
                got_len++;
            end
            if (busy !== 1'b1) begin
                busy_held = 1'b0;
            end
            prev_wr = tx_wr;
            n++;
            @(negedge clk);
        end
        done_at   = n;
        done_busy = busy;
        done_wr   = tx_wr;
        @(negedge clk);
        done_after = done;
    endtask

    task automatic verify_message(input string exp);
        check_len("tx_wr count", char_idx_t'(exp.len()), char_idx_t'(got_len));
        for (int i = 0; i < exp.len(); i++) begin
            check_char($sformatf("tx_data[%0d]", i), char_t'(exp[i]), got_chars[i]);
        end
        // done follows the last write
        check_len("done cycle", char_idx_t'(exp.len() + 2), char_idx_t'(done_at));
        check_flag("busy with done", 1'b0, done_busy);
        check_flag("tx_wr with done", 1'b0, done_wr);
    endtask

    task automatic run_message(input mode_t m, input dist_t d, input hour_t h, input min_t mi,
            input sec_t s, input reading_t t, input reading_t hu);
        drive_start(m, d, h, mi, s, t, hu);
        collect_message();
        verify_message(expected_line(m, d, h, mi, s, t, hu));
    endtask

    task automatic check_outputs_idle();
        check_flag("tx_wr", 1'b0, tx_wr);
        check_flag("done", 1'b0, done);
        check_flag("busy", 1'b0, busy);
        check_char("tx_data", 8'h00, tx_data);
    endtask

    task automatic test_reset();
        repeat (8) begin
            @(negedge clk);
            check_outputs_idle();
        end
        @(posedge clk);
        reset <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_outputs_idle();
        end
    endtask

    task automatic test_distance();
        dist_t fixed [4] = '{9'd0, 9'd9, 9'd100, 9'd511};
        foreach (fixed[i]) begin
            run_message(2'd2, fixed[i], 5'd0, 6'd0, 6'd0, 8'd0, 8'd0);
        end
        for (int i = 0; i < 10; i++) begin
            run_message(2'd2, dist_t'($urandom), hour_t'($urandom), min_t'($urandom),
                        sec_t'($urandom), reading_t'($urandom), reading_t'($urandom));
        end
    endtask

    task automatic test_clock();
        run_message(2'd0, 9'd0, 5'd0, 6'd0, 6'd0, 8'd0, 8'd0);
        run_message(2'd1, 9'd0, 5'd23, 6'd59, 6'd59, 8'd0, 8'd0);
        run_message(2'd0, 9'd0, 5'd31, 6'd63, 6'd63, 8'd0, 8'd0);
        for (int i = 0; i < 8; i++) begin
            run_message(mode_t'(i % 2), dist_t'($urandom), hour_t'($urandom), min_t'($urandom),
                        sec_t'($urandom), reading_t'($urandom), reading_t'($urandom));
        end
    endtask

    task automatic test_climate();
        run_message(2'd3, 9'd0, 5'd0, 6'd0, 6'd0, 8'd255, 8'd0);
        run_message(2'd3, 9'd0, 5'd0, 6'd0, 6'd0, 8'd0, 8'd255);
        for (int i = 0; i < 8; i++) begin
            run_message(2'd3, dist_t'($urandom), hour_t'($urandom), min_t'($urandom),
                        sec_t'($urandom), reading_t'($urandom), reading_t'($urandom));
        end
    endtask

    task automatic test_capture_busy();
        string exp;
        exp = expected_line(2'd2, 9'd307, 5'd4, 6'd5, 6'd6, 8'd77, 8'd88);
        drive_start(2'd2, 9'd307, 5'd4, 6'd5, 6'd6, 8'd77, 8'd88);
        // new mode and readings right after E0
        mode         <= 2'd3;
        distance_bin <= 9'd42;
        temp         <= 8'd1;
        humid        <= 8'd2;
        hour         <= 5'd17;
        fork
            collect_message();
            begin
                // one pulse mid-message, one sampled in the done cycle
                repeat (3) @(posedge clk);
                start <= 1'b1;
                @(posedge clk);
                start <= 1'b0;
                repeat (11) @(posedge clk);
                start <= 1'b1;
                @(posedge clk);
                start <= 1'b0;
            end
        join
        verify_message(exp);
        repeat (25) begin
            @(negedge clk);
            check_flag("tx_wr after message", 1'b0, tx_wr);
            check_flag("busy after message", 1'b0, busy);
        end
    endtask

    task automatic test_timing();
        for (int k = 0; k < 3; k++) begin
            run_message(mode_t'(k + 1), 9'd123, 5'd12, 6'd34, 6'd56, 8'd78, 8'd90);
            check_len("first tx_wr offset", 5'd2, char_idx_t'(first_wr));
            check_flag("tx_wr contiguous", 1'b1, contiguous);
            check_flag("busy held", 1'b1, busy_held);
            check_flag("done single cycle", 1'b0, done_after);
        end
    endtask

    initial begin
        void'($urandom(32'hd391_ff13));
        clk          = 1'b0;
        reset        = 1'b1;
        start        = 1'b0;
        distance_bin = '0;
        mode         = '0;
        sec          = '0;
        min          = '0;
        hour         = '0;
        humid        = '0;
        temp         = '0;
        cycles       = 0;
        test_reset();
        test_distance();
        test_clock();
        test_climate();
        test_capture_busy();
        test_timing();
        $display("all tests passed");
        $finish;
    end

endmodule

//--- build.f
common/print_types_pkg.sv
common/print_text_pkg.sv
common/print_seq_if.sv
verilog/print_ctrl_fsm.sv
verilog/char_counter.sv
verilog/reading_to_decimal.sv
verilog/message_composer.sv
verilog/print_gen_top.sv
verif/print_gen_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module print_gen_tb \
    --Mdir obj_dir -o print_gen_sim \
    -f build.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/print_gen_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0
